//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := attribute_interpolator_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/attribute_interpolator.sv
// Per-pixel attribute stage, 20 enabled cycles from input to output
// m_ready is the pipeline enable; s_ready follows it directly
// Upstream holds s_valid and s_side while s_ready is low
// tri_attr must be stable while a triangle command is valid
`timescale 1ns/100ps

module attribute_interpolator (
    input  logic                              aclk,
    input  logic                              arst_n,

    // Command stream from the edge walker
    input  logic                              s_valid,
    output logic                              s_ready,
    input  logic [raster_pkg::cmd_width-1:0]  s_cmd,
    input  raster_pkg::pixel_side_t           s_side,
    input  raster_pkg::triangle_attr_t        tri_attr,

    // Interpolated pixels towards the texture unit
    input  logic                              m_ready,
    output logic                              m_valid,
    output raster_pkg::pixel_out_t            m_data
);
    import raster_pkg::*;

    logic        ce;
    logic        step_valid;
    pixel_side_t step_side;
    pixel_attr_t step_attr;

    // Whole pipeline stalls on downstream back-pressure
    assign ce      = m_ready;
    assign s_ready = m_ready;

    attribute_stepper stepper (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .ce       (ce),
        .valid    (s_valid),
        .cmd      (s_cmd),
        .side_in  (s_side),
        .tri_attr (tri_attr),
        .out_valid(step_valid),
        .side_out (step_side),
        .attr_out (step_attr)
    );

    perspective_correction correction (
        .aclk   (aclk),
        .arst_n (arst_n),
        .ce     (ce),
        .valid  (step_valid),
        .side_in(step_side),
        .attr_in(step_attr),
        .m_valid(m_valid),
        .m_data (m_data)
    );

endmodule

//--- source/attribute_stepper.sv
// Evaluates base + inc_x*spx + inc_y*spy for all planes, wrapped to 32 bits
// Two enabled cycles deep; triangle beats leave with valid low
// A triangle command applies to pixels accepted after it
`timescale 1ns/100ps

module attribute_stepper (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              ce,
    input  logic                              valid,
    input  logic [raster_pkg::cmd_width-1:0]  cmd,
    input  raster_pkg::pixel_side_t           side_in,
    input  raster_pkg::triangle_attr_t        tri_attr,
    output logic                              out_valid,
    output raster_pkg::pixel_side_t           side_out,
    output raster_pkg::pixel_attr_t           attr_out
);
    import raster_pkg::*;

    triangle_attr_t                            tri_q;
    plane_t [num_planes-1:0]                   planes;
    logic [num_planes-1:0][attr_width-1:0]     base_s1;
    logic [num_planes-1:0][attr_width-1:0]     prod_x_s1;
    logic [num_planes-1:0][attr_width-1:0]     prod_y_s1;
    logic [num_planes-1:0][attr_width-1:0]     sum_s2;
    logic                                      valid_s1;
    logic                                      valid_s2;
    pixel_side_t                               side_s1;
    pixel_side_t                               side_s2;

    // Indexed view of the stored set, tex_s at the top
    assign planes = tri_q;

    always_ff @(posedge aclk) begin
        if (ce && valid && (cmd == cmd_triangle)) begin
            tri_q <= tri_attr;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (ce) begin
            valid_s1 <= valid && (cmd == cmd_pixel);   // Only pixels produce output
            valid_s2 <= valid_s1;
        end
    end

    // Products keep the low 32 bits, sign of the step does not matter there
    always_ff @(posedge aclk) begin
        if (ce) begin
            side_s1 <= side_in;
            for (int i = 0; i < num_planes; i++) begin
                base_s1[i]   <= planes[i].base;
                prod_x_s1[i] <= planes[i].inc_x * attr_width'(side_in.spx);
                prod_y_s1[i] <= planes[i].inc_y * attr_width'(side_in.spy);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            side_s2 <= side_s1;
            for (int i = 0; i < num_planes; i++) begin
                sum_s2[i] <= base_s1[i] + prod_x_s1[i] + prod_y_s1[i];
            end
        end
    end

    assign out_valid = valid_s2;
    assign side_out  = side_s2;
    assign attr_out  = sum_s2;

endmodule

//--- source/delay_line.sv
// Enable-gated register chain of any packed type, DEPTH of at least 1
// Cleared to zero on reset so delayed valid bits start low
`timescale 1ns/100ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic aclk,
    input  logic arst_n,
    input  logic ce,
    input  T     din,
    output T     dout
);

    T taps [DEPTH];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else if (ce) begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];   // Shift one step per enabled cycle
            end
        end
    end

    assign dout = taps[DEPTH-1];

endmodule

//--- source/divider_pipe.sv
// Unsigned restoring divider, one quotient bit per stage, quot_width stages
// ovf flags num/den >= 2**quot_width, which covers a zero divisor
// No reset here; the matching valid travels in a separate delay line
`timescale 1ns/100ps

module divider_pipe #(
    parameter int NUM_WIDTH = 36,
    parameter int DEN_WIDTH = 32
) (
    input  logic                              aclk,
    input  logic                              ce,
    input  logic [NUM_WIDTH-1:0]              num,
    input  logic [DEN_WIDTH-1:0]              den,
    output logic [raster_pkg::quot_width-1:0] quot,
    output logic                              ovf
);
    import raster_pkg::*;

    localparam int wide = NUM_WIDTH + DEN_WIDTH;

    logic [NUM_WIDTH-1:0]  rem_q  [quot_width-1];   // Last stage drops the remainder
    logic [DEN_WIDTH-1:0]  den_q  [quot_width-1];
    logic [quot_width-1:0] quot_q [quot_width];
    logic                  ovf_q  [quot_width];

    for (genvar k = 0; k < quot_width; k++) begin : g_stage
        localparam int shift = quot_width - 1 - k;   // Quotient bit of this stage

        logic [NUM_WIDTH-1:0]  rem_in;
        logic [DEN_WIDTH-1:0]  den_in;
        logic [quot_width-1:0] quot_in;
        logic                  ovf_in;
        logic [wide-1:0]       trial;
        logic                  fits;

        if (k == 0) begin : g_head
            assign rem_in  = num;
            assign den_in  = den;
            assign quot_in = '0;
            assign ovf_in  = (wide'(num) >> quot_width) >= wide'(den);
        end else begin : g_tail
            assign rem_in  = rem_q[k-1];
            assign den_in  = den_q[k-1];
            assign quot_in = quot_q[k-1];
            assign ovf_in  = ovf_q[k-1];
        end

        assign trial = wide'(den_in) << shift;
        assign fits  = wide'(rem_in) >= trial;

        always_ff @(posedge aclk) begin
            if (ce) begin
                quot_q[k] <= quot_in | (quot_width'(fits) << shift);
                ovf_q[k]  <= ovf_in;
            end
        end

        if (k < quot_width - 1) begin : g_carry
            always_ff @(posedge aclk) begin
                if (ce) begin
                    rem_q[k] <= fits ? NUM_WIDTH'(wide'(rem_in) - trial) : rem_in;
                    den_q[k] <= den_in;
                end
            end
        end
    end

    assign quot = quot_q[quot_width-1];
    assign ovf  = ovf_q[quot_width-1];

endmodule

//--- source/perspective_correction.sv
// Divides s and t by q into S11.4, clamps colour to 8 bits, saturates z to 16 bits
// 18 enabled cycles: setup, 16 divider stages, format
// Texture coordinates saturate to +-32767 on overflow or zero q
`timescale 1ns/100ps

module perspective_correction (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic                         ce,
    input  logic                         valid,
    input  raster_pkg::pixel_side_t      side_in,
    input  raster_pkg::pixel_attr_t      attr_in,
    output logic                         m_valid,
    output raster_pkg::pixel_out_t       m_data
);
    import raster_pkg::*;

    typedef struct packed {
        logic        valid;
        pixel_side_t side;
    } side_beat_t;

    // Everything that bypasses the dividers, signs included
    typedef struct packed {
        logic                       sign_s;
        logic                       sign_t;
        logic [depth_out_width-1:0] depth_z;
        logic [color_out_width-1:0] color_r;
        logic [color_out_width-1:0] color_g;
        logic [color_out_width-1:0] color_b;
        logic [color_out_width-1:0] color_a;
    } fmt_payload_t;

    logic [attr_width-1:0]    abs_s;
    logic [attr_width-1:0]    abs_t;
    logic [div_num_width-1:0] num_s_q;
    logic [div_num_width-1:0] num_t_q;
    logic [attr_width-1:0]    den_q;
    logic [quot_width-1:0]    quot_s;
    logic [quot_width-1:0]    quot_t;
    logic                     ovf_s;
    logic                     ovf_t;
    side_beat_t               beat_in;
    side_beat_t               beat_d;
    fmt_payload_t             fmt_in;
    fmt_payload_t             fmt_d;

    // Integer part of S8.23, positive range already ends at 255
    function automatic logic [color_out_width-1:0] clamp_color(input logic [attr_width-1:0] c);
        return c[attr_width-1] ? '0 : c[color_frac_bits +: color_out_width];
    endfunction

    function automatic logic [depth_out_width-1:0] depth_fmt(input logic [attr_width-1:0] z);
        if (z[attr_width-1]) begin
            return '0;
        end
        if (z[depth_frac_bits]) begin
            return '1;   // 1.0 and above
        end
        return z[depth_frac_bits-1 -: depth_out_width];
    endfunction

    function automatic logic [tex_out_width-1:0] tex_fmt(input logic [quot_width-1:0] quot,
                                                         input logic ovf,
                                                         input logic neg);
        logic [tex_out_width-1:0] mag;
        mag = (ovf || quot[quot_width-1]) ? tex_max : quot;
        return neg ? -mag : mag;
    endfunction

    assign abs_s = attr_in.tex_s[attr_width-1] ? -attr_in.tex_s : attr_in.tex_s;
    assign abs_t = attr_in.tex_t[attr_width-1] ? -attr_in.tex_t : attr_in.tex_t;

    assign beat_in.valid = valid;
    assign beat_in.side  = side_in;

    assign fmt_in.sign_s  = attr_in.tex_s[attr_width-1];
    assign fmt_in.sign_t  = attr_in.tex_t[attr_width-1];
    assign fmt_in.depth_z = depth_fmt(attr_in.depth_z);
    assign fmt_in.color_r = clamp_color(attr_in.color_r);
    assign fmt_in.color_g = clamp_color(attr_in.color_g);
    assign fmt_in.color_b = clamp_color(attr_in.color_b);
    assign fmt_in.color_a = clamp_color(attr_in.color_a);

    // Setup stage, numerator gets the output fraction bits
    always_ff @(posedge aclk) begin
        if (ce) begin
            num_s_q <= div_num_width'(abs_s) << tex_frac_bits;
            num_t_q <= div_num_width'(abs_t) << tex_frac_bits;
            den_q   <= attr_in.tex_q;
        end
    end

    divider_pipe #(.NUM_WIDTH(div_num_width), .DEN_WIDTH(attr_width)) div_s (
        .aclk(aclk), .ce(ce), .num(num_s_q), .den(den_q), .quot(quot_s), .ovf(ovf_s)
    );

    divider_pipe #(.NUM_WIDTH(div_num_width), .DEN_WIDTH(attr_width)) div_t (
        .aclk(aclk), .ce(ce), .num(num_t_q), .den(den_q), .quot(quot_t), .ovf(ovf_t)
    );

    // Setup plus divider depth, so both meet the quotients
    delay_line #(.T(side_beat_t), .DEPTH(correction_latency - 1)) side_delay (
        .aclk(aclk), .arst_n(arst_n), .ce(ce), .din(beat_in), .dout(beat_d)
    );

    delay_line #(.T(fmt_payload_t), .DEPTH(correction_latency - 1)) fmt_delay (
        .aclk(aclk), .arst_n(arst_n), .ce(ce), .din(fmt_in), .dout(fmt_d)
    );

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (ce) begin
            m_valid <= beat_d.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            m_data.side    <= beat_d.side;
            m_data.tex_s   <= tex_fmt(quot_s, ovf_s, fmt_d.sign_s);
            m_data.tex_t   <= tex_fmt(quot_t, ovf_t, fmt_d.sign_t);
            m_data.depth_z <= fmt_d.depth_z;
            m_data.color_r <= fmt_d.color_r;
            m_data.color_g <= fmt_d.color_g;
            m_data.color_b <= fmt_d.color_b;
            m_data.color_a <= fmt_d.color_a;
        end
    end

endmodule

//--- source/raster_pkg.sv
// Shared widths, formats and pixel stream types of the attribute stage
// Inputs: texture s, t, q in S15.16, colour in S8.23, depth z in S1.30
// q is expected to be positive; a zero q saturates the texture coordinate
// The plane order in triangle_attr_t and pixel_attr_t must stay identical
package raster_pkg;

    localparam int screen_pos_width = 11;
    localparam int index_width      = 32;
    localparam int attr_width       = 32;
    localparam int num_planes       = 8;

    // Edge walker command codes
    localparam int                    cmd_width    = 2;
    localparam logic [cmd_width-1:0] cmd_pixel    = 2'd0;
    localparam logic [cmd_width-1:0] cmd_triangle = 2'd1;

    // Fixed point formats
    localparam int tex_frac_bits   = 4;    // Output texture S11.4
    localparam int color_frac_bits = 23;   // S8.23
    localparam int depth_frac_bits = 30;   // S1.30

    localparam int quot_width      = 16;
    localparam int div_num_width   = attr_width + tex_frac_bits;
    localparam int tex_out_width   = quot_width;
    localparam int depth_out_width = 16;
    localparam int color_out_width = 8;
    localparam logic [tex_out_width-1:0] tex_max = 16'h7fff;

    // Pipeline depths in enabled cycles
    localparam int stepper_latency    = 2;
    localparam int correction_latency = quot_width + 2;   // Setup, divider, format
    localparam int interp_latency     = stepper_latency + correction_latency;

    typedef struct packed {
        logic signed [attr_width-1:0] base;
        logic signed [attr_width-1:0] inc_x;
        logic signed [attr_width-1:0] inc_y;
    } plane_t;

    typedef struct packed {
        plane_t tex_s;
        plane_t tex_t;
        plane_t tex_q;
        plane_t depth_z;
        plane_t color_r;
        plane_t color_g;
        plane_t color_b;
        plane_t color_a;
    } triangle_attr_t;

    typedef struct packed {
        logic                        pixel;
        logic                        last;
        logic [screen_pos_width-1:0] spx;
        logic [screen_pos_width-1:0] spy;
        logic [index_width-1:0]      index;
    } pixel_side_t;

    // Same plane order as triangle_attr_t
    typedef struct packed {
        logic signed [attr_width-1:0] tex_s;
        logic signed [attr_width-1:0] tex_t;
        logic signed [attr_width-1:0] tex_q;
        logic signed [attr_width-1:0] depth_z;
        logic signed [attr_width-1:0] color_r;
        logic signed [attr_width-1:0] color_g;
        logic signed [attr_width-1:0] color_b;
        logic signed [attr_width-1:0] color_a;
    } pixel_attr_t;

    typedef struct packed {
        pixel_side_t                side;
        logic [tex_out_width-1:0]   tex_s;
        logic [tex_out_width-1:0]   tex_t;
        logic [depth_out_width-1:0] depth_z;
        logic [color_out_width-1:0] color_r;
        logic [color_out_width-1:0] color_g;
        logic [color_out_width-1:0] color_b;
        logic [color_out_width-1:0] color_a;
    } pixel_out_t;

endpackage

//--- sources.f
source/raster_pkg.sv
source/delay_line.sv
source/divider_pipe.sv
source/attribute_stepper.sv
source/perspective_correction.sv
source/attribute_interpolator.sv
tests/attribute_interpolator_properties.sv
tests/attribute_interpolator_tb.sv

//--- tests/attribute_interpolator_properties.sv
// Handshake and reset checks, bound to every attribute_interpolator
// m_ready doubles as the pipeline enable, so a stalled beat must hold
`timescale 1ns/100ps

module attribute_interpolator_properties (
    input logic                   aclk,
    input logic                   arst_n,
    input logic                   s_ready,
    input logic                   m_ready,
    input logic                   m_valid,
    input raster_pkg::pixel_out_t m_data
);

    // Valid registers clear asynchronously
    reset_clears_valid: assert property (@(posedge aclk) !arst_n |-> !m_valid)
        else $error("m_valid high while reset is asserted");

    ready_follows: assert property (@(posedge aclk) disable iff (!arst_n)
        s_ready == m_ready)
        else $error("s_ready differs from m_ready");

    stall_holds_data: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else $error("Output beat changed while stalled");

endmodule

bind attribute_interpolator attribute_interpolator_properties props (
    .aclk   (aclk),
    .arst_n (arst_n),
    .s_ready(s_ready),
    .m_ready(m_ready),
    .m_valid(m_valid),
    .m_data (m_data)
);

//--- tests/attribute_interpolator_tb.sv
// Table-driven testbench for the attribute stage with a reference model
// Expected pixels queue up in command order; a monitor checks every output beat
// Second half of the table runs with random back-pressure on m_ready
`timescale 1ns/100ps

module attribute_interpolator_tb;
    import raster_pkg::*;

    localparam time clk_period = 40ns;

    logic                 clk;
    logic                 arst_n;
    logic                 s_valid;
    logic                 s_ready;
    logic [cmd_width-1:0] s_cmd;
    pixel_side_t          s_side;
    triangle_attr_t       tri_attr;
    logic                 m_ready;
    logic                 m_valid;
    pixel_out_t           m_data;

    // One stimulus table entry per command
    string          tbl_name   [$];
    bit             tbl_is_tri [$];
    pixel_side_t    tbl_side   [$];
    triangle_attr_t tbl_tri    [$];

    pixel_out_t exp_q    [$];
    string      name_q   [$];
    int         accept_q [$];   // Enabled-edge count at acceptance

    int             seed = 30;
    int             value_errors = 0;
    int             latency_errors = 0;
    int             order_errors = 0;
    int             en_count = 0;
    bit             random_ready = 1'b0;
    bit             table_built = 1'b0;
    triangle_attr_t cur_tri;

    attribute_interpolator DUT (
        .aclk    (clk),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_cmd   (s_cmd),
        .s_side  (s_side),
        .tri_attr(tri_attr),
        .m_ready (m_ready),
        .m_valid (m_valid),
        .m_data  (m_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic triangle_attr_t make_tri(input int s, s_dx, t, t_dy, q, q_dy,
                                                input int z, z_dx, r, g, b, a);
        triangle_attr_t ts;
        ts.tex_s   = '{s, s_dx, 0};
        ts.tex_t   = '{t, 0, t_dy};
        ts.tex_q   = '{q, 0, q_dy};
        ts.depth_z = '{z, z_dx, 0};
        ts.color_r = '{r, 0, 0};   // Colour planes are flat
        ts.color_g = '{g, 0, 0};
        ts.color_b = '{b, 0, 0};
        ts.color_a = '{a, 0, 0};
        return ts;
    endfunction

    task automatic add_triangle(input string name, input triangle_attr_t ts);
        tbl_name.push_back(name);
        tbl_is_tri.push_back(1'b1);
        tbl_side.push_back('0);
        tbl_tri.push_back(ts);
    endtask

    task automatic add_pixel(input string name, input int spx, spy, input bit last);
        pixel_side_t sd;
        sd.pixel = 1'b1;
        sd.last  = last;
        sd.spx   = screen_pos_width'(spx);
        sd.spy   = screen_pos_width'(spy);
        sd.index = 32'(tbl_name.size());   // Unique per entry
        tbl_name.push_back($sformatf("%s_%0d", name, tbl_name.size()));
        tbl_is_tri.push_back(1'b0);
        tbl_side.push_back(sd);
        tbl_tri.push_back('0);
    endtask

    // Plane value at the pixel wrapped to 32 bits
    function automatic logic [31:0] eval_plane(input plane_t p, input pixel_side_t sd);
        return p.base + p.inc_x * 32'(sd.spx) + p.inc_y * 32'(sd.spy);
    endfunction

    // S15.16 over S15.16 gives S11.4 once the numerator carries 4 extra bits
    function automatic logic [15:0] expect_tex(input logic [31:0] s, input logic [31:0] q);
        logic [63:0] quot;
        logic [15:0] mag;
        quot = (q == 0) ? 64'hffff : ({32'd0, (s[31] ? -s : s)} << 4) / {32'd0, q};
        mag  = (quot > 64'd32767) ? 16'h7fff : quot[15:0];
        return s[31] ? -mag : mag;
    endfunction

    function automatic logic [15:0] expect_depth(input logic [31:0] z);
        return z[31] ? 16'h0000 : (z >= 32'h4000_0000) ? 16'hffff : 16'(z >> 14);
    endfunction

    function automatic logic [7:0] expect_color(input logic [31:0] c);
        return c[31] ? 8'd0 : ((c >> 23) > 32'd255) ? 8'd255 : 8'(c >> 23);
    endfunction

    function automatic pixel_out_t model_pixel(input triangle_attr_t ts, input pixel_side_t sd);
        pixel_out_t  o;
        logic [31:0] q;
        q         = eval_plane(ts.tex_q, sd);
        o.side    = sd;
        o.tex_s   = expect_tex(eval_plane(ts.tex_s, sd), q);
        o.tex_t   = expect_tex(eval_plane(ts.tex_t, sd), q);
        o.depth_z = expect_depth(eval_plane(ts.depth_z, sd));
        o.color_r = expect_color(eval_plane(ts.color_r, sd));
        o.color_g = expect_color(eval_plane(ts.color_g, sd));
        o.color_b = expect_color(eval_plane(ts.color_b, sd));
        o.color_a = expect_color(eval_plane(ts.color_a, sd));
        return o;
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s %s expected %0h actual %0h", name, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_output();
        pixel_out_t e;
        string      name;
        int         accepted;
        assert (exp_q.size() != 0 && accept_q.size() != 0) else begin
            $display("Extra output beat with index %0h and no pixel outstanding",
                     m_data.side.index);
            order_errors++;
        end
        if (exp_q.size() != 0 && accept_q.size() != 0) begin
            e        = exp_q.pop_front();
            name     = name_q.pop_front();
            accepted = accept_q.pop_front();
            compare_field(name, "index", e.side.index, m_data.side.index);
            compare_field(name, "spx", 32'(e.side.spx), 32'(m_data.side.spx));
            compare_field(name, "spy", 32'(e.side.spy), 32'(m_data.side.spy));
            compare_field(name, "flags", 32'({e.side.pixel, e.side.last}),
                          32'({m_data.side.pixel, m_data.side.last}));
            compare_field(name, "tex_s", 32'(e.tex_s), 32'(m_data.tex_s));
            compare_field(name, "tex_t", 32'(e.tex_t), 32'(m_data.tex_t));
            compare_field(name, "depth_z", 32'(e.depth_z), 32'(m_data.depth_z));
            compare_field(name, "rgba", {e.color_r, e.color_g, e.color_b, e.color_a},
                          {m_data.color_r, m_data.color_g, m_data.color_b, m_data.color_a});
            assert (en_count - accepted == interp_latency) else begin
                $display("Fail %s latency expected %0d actual %0d", name, interp_latency,
                         en_count - accepted);
                latency_errors++;
            end
        end
    endtask

    task automatic report_counts();
        $display("Errors: value %0d, latency %0d, order %0d",
                 value_errors, latency_errors, order_errors);
    endtask

    // Counts enabled edges and checks each output beat against the queue
    always @(posedge clk) begin
        if (arst_n) begin
            if (s_valid && s_ready && s_cmd == cmd_pixel) begin
                accept_q.push_back(en_count);
            end
            if (m_valid && m_ready) begin
                check_output();
            end
            if (m_ready) begin
                en_count++;
            end
        end
    end

    always @(posedge clk) begin
        m_ready <= random_ready ? ($random(seed) % 4 != 0) : 1'b1;   // About 75% ready
    end

    initial begin
        arst_n   <= 1'b0;
        s_valid  <= 1'b0;
        s_cmd    <= cmd_pixel;
        s_side   <= '0;
        tri_attr <= '0;
        m_ready  <= 1'b1;
        cur_tri  = '0;

        // Flat colour and depth, linear s and t, q = 1.0
        add_triangle("plane_eval", make_tri(32'h000a_0000, 32'h0001_0000, -327680, 32'h8000,
                     32'h0001_0000, 0, 32'h2000_0000, 0, 32'h3240_0000, 32'h0080_0000,
                     32'h7f80_0000, 0));
        add_pixel("plane_eval", 0, 0, 1'b0);
        add_pixel("plane_eval", 3, 1, 1'b0);
        add_pixel("plane_eval", 100, 7, 1'b0);
        add_pixel("plane_eval", 2047, 2047, 1'b1);
        // Sent while the pixels above are still in flight
        add_triangle("persp_div", make_tri(-196608, 32'h4000, 32'h0007_0000, -32768,
                     32'h8000, 32'h0001_0000, 0, 0, 32'h0100_0000, 32'h0280_0000,
                     32'h0400_0000, 32'h7000_0000));
        add_pixel("persp_div", 0, 0, 1'b0);
        add_pixel("persp_div", 4, 1, 1'b0);
        add_pixel("persp_div", 20, 3, 1'b0);
        add_pixel("persp_div", 40, 9, 1'b1);
        add_triangle("saturate", make_tri(32'h4000_0000, 0, -32'sh4000_0000, 0, 0,
                     32'h0001_0000, 32'h4000_0000, -32'sh1000_0000, -1, 32'h7fff_ffff,
                     -32'sh0080_0000, 0));
        add_pixel("saturate", 0, 0, 1'b0);
        add_pixel("saturate", 1, 0, 1'b0);
        add_pixel("saturate", 5, 1, 1'b0);
        add_pixel("saturate", 2, 3, 1'b1);
        add_triangle("backpressure", make_tri(32'h0001_0000, 32'h100, 32'h0002_0000, 32'h200,
                     32'h0002_0000, 32'h800, 32'h0100_0000, 32'h0010_0000, 32'h0880_0000,
                     32'h1100_0000, 32'h2200_0000, 32'h4400_0000));
        for (int k = 0; k < 8; k++) begin
            add_pixel("backpressure", 7 * k, 3 * k + 1, k == 7);
        end
        table_built = 1'b1;

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < tbl_name.size(); i++) begin
            random_ready <= (i >= tbl_name.size() / 2);
            s_valid      <= 1'b1;
            s_cmd        <= tbl_is_tri[i] ? cmd_triangle : cmd_pixel;
            s_side       <= tbl_side[i];
            if (tbl_is_tri[i]) begin
                tri_attr <= tbl_tri[i];
                cur_tri   = tbl_tri[i];   // Applies to later pixels only
            end else begin
                exp_q.push_back(model_pixel(cur_tri, tbl_side[i]));
                name_q.push_back(tbl_name[i]);
            end
            @(posedge clk);
            while (!s_ready) begin
                @(posedge clk);
            end
        end
        s_valid <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (interp_latency + 4) @(posedge clk);   // Catch late extra beats
        report_counts();
        if (value_errors + latency_errors + order_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (table_built);
        #((tbl_name.size() + interp_latency) * 4 * clk_period);
        $display("Timeout with %0d pixels still missing at the output", exp_q.size());
        report_counts();
        $display("Regression failed");
        $finish;
    end

endmodule
